//--- project.f
verilog/frontend_pkg.sv
verilog/pc_gen.sv
verilog/fetch_buffer.sv
verilog/instr_scan.sv
verilog/bht.sv
verilog/instr_queue.sv
verilog/fetch_frontend.sv
bench/tb_imem.sv
bench/tb_fetch_frontend.sv

//--- Makefile
TOP := tb_fetch_frontend

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "^=== PASS ===$$" sim.log; then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- bench/tb_fetch_frontend.sv
// one reset at the start, rows run back to back; each row collects its first 8 entries
module tb_fetch_frontend
  import frontend_pkg::*;
();

  localparam int NUM_ROWS = 8;
  // entries collected per row
  localparam int N        = 8;
  localparam int TIMEOUT  = 400;

  localparam logic [1:0] K_BOOT       = 2'd0;
  localparam logic [1:0] K_REDIRECT   = 2'd1;
  localparam logic [1:0] K_MISPREDICT = 2'd2;

  typedef struct packed {
    logic [1:0]      kind;
    logic            train;       // not-taken resolve at train_pc before the redirect
    logic [VLEN-1:0] train_pc;
    logic [VLEN-1:0] target;      // boot address, redirect or mispredict target
    logic            rand_ready;  // decode ready at 50 percent
    logic [N-1:0]    taken_mask;  // bit i set, entry i predicted taken
    logic [N-1:0]    branch_mask; // bit i set, entry i is a conditional branch
  } row_t;

  logic            clk_i;
  logic            rst_ni;
  logic [VLEN-1:0] boot_addr;
  redirect_t       redirect;
  resolve_t        resolve;
  fetch_req_t      fetch_req;
  logic            fetch_gnt;
  fetch_rsp_t      fetch_rsp;
  fetch_entry_t    fetch_entry;
  logic            fetch_valid;
  logic            fetch_ready;

  row_t            rows [NUM_ROWS];
  logic [VLEN-1:0] exp_pc [NUM_ROWS][N];
  string           names [NUM_ROWS];
  int              errors;
  int              failed_tests;

  fetch_frontend #(
    .NR_OUTSTANDING(4),
    .QUEUE_DEPTH   (8),
    .BHT_ENTRIES   (64)
  ) dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .boot_addr_i  (boot_addr),
    .redirect_i   (redirect),
    .resolve_i    (resolve),
    .fetch_req_o  (fetch_req),
    .fetch_gnt_i  (fetch_gnt),
    .fetch_rsp_i  (fetch_rsp),
    .fetch_entry_o(fetch_entry),
    .fetch_valid_o(fetch_valid),
    .fetch_ready_i(fetch_ready)
  );

  tb_imem u_imem (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .req_i (fetch_req),
    .gnt_o (fetch_gnt),
    .rsp_o (fetch_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // stimulus table
  // --------------------------------------------------
  task automatic load_table();
    // kind, train, train_pc, target, rand_ready, taken_mask, branch_mask
    rows[0] = '{K_BOOT,       1'b0, 32'h0,    32'h1000, 1'b0, 8'b0000_1000, 8'b0000_0000};
    rows[1] = '{K_REDIRECT,   1'b0, 32'h0,    32'h1008, 1'b0, 8'b0000_0010, 8'b0000_0000};
    rows[2] = '{K_REDIRECT,   1'b0, 32'h0,    32'h2000, 1'b0, 8'b0010_0100, 8'b0010_0100};
    rows[3] = '{K_REDIRECT,   1'b0, 32'h0,    32'h3000, 1'b0, 8'b0000_0000, 8'b0000_0010};
    rows[4] = '{K_REDIRECT,   1'b1, 32'h2008, 32'h2000, 1'b0, 8'b0000_0000, 8'b0000_0100};
    rows[5] = '{K_MISPREDICT, 1'b0, 32'h0,    32'h4000, 1'b0, 8'b0001_0000, 8'b0000_0000};
    rows[6] = '{K_REDIRECT,   1'b0, 32'h0,    32'h1000, 1'b1, 8'b0000_1000, 8'b0000_0000};
    rows[7] = '{K_MISPREDICT, 1'b0, 32'h0,    32'h4000, 1'b1, 8'b0001_0000, 8'b0000_0000};
    exp_pc[0] = '{32'h1000, 32'h1004, 32'h1008, 32'h100C, 32'h102C, 32'h1030, 32'h1034, 32'h1038};
    exp_pc[1] = '{32'h1008, 32'h100C, 32'h102C, 32'h1030, 32'h1034, 32'h1038, 32'h103C, 32'h1040};
    // backward loop, untrained so static taken
    exp_pc[2] = '{32'h2000, 32'h2004, 32'h2008, 32'h2000, 32'h2004, 32'h2008, 32'h2000, 32'h2004};
    exp_pc[3] = '{32'h3000, 32'h3004, 32'h3008, 32'h300C, 32'h3010, 32'h3014, 32'h3018, 32'h301C};
    // same loop after training, falls through
    exp_pc[4] = '{32'h2000, 32'h2004, 32'h2008, 32'h200C, 32'h2010, 32'h2014, 32'h2018, 32'h201C};
    exp_pc[5] = '{32'h4000, 32'h4004, 32'h4008, 32'h400C, 32'h4010, 32'h4000, 32'h4004, 32'h4008};
    exp_pc[6] = exp_pc[0];
    exp_pc[7] = exp_pc[5];
    names[0] = "boot sequence and jal";
    names[1] = "redirect onto jal";
    names[2] = "untrained backward branch";
    names[3] = "untrained forward branch";
    names[4] = "trained branch not taken";
    names[5] = "mispredict and backward jal";
    names[6] = "random ready after redirect";
    names[7] = "random ready after mispredict";
  endtask

  function automatic logic pick_ready(input logic rand_mode);
    return rand_mode ? ($urandom_range(1, 0) == 1) : 1'b1;
  endfunction

  // --------------------------------------------------
  // per entry checks
  // --------------------------------------------------
  task automatic check_entry(input int r, input int i, input fetch_entry_t e, inout int errs);
    logic [ILEN-1:0] word;
    cf_e             exp_cf;
    word = u_imem.program_word(e.pc);
    // jal is the only non-branch in the program that is ever predicted taken
    if (rows[r].branch_mask[i]) begin
      exp_cf = CF_BRANCH;
    end else if (rows[r].taken_mask[i]) begin
      exp_cf = CF_JUMP;
    end else begin
      exp_cf = CF_NONE;
    end
    assert (e.pc == exp_pc[r][i]) else begin
      $display("** Error @%0t: fetch_entry_o.pc = %h, expected %h", $time, e.pc, exp_pc[r][i]);
      errs++;
    end
    assert (e.instr == word) else begin
      $display("** Error @%0t: fetch_entry_o.instr = %h, expected %h", $time, e.instr, word);
      errs++;
    end
    assert (e.predict_taken == rows[r].taken_mask[i]) else begin
      $display("** Error @%0t: fetch_entry_o.predict_taken = %b, expected %b",
               $time, e.predict_taken, rows[r].taken_mask[i]);
      errs++;
    end
    assert (e.cf == exp_cf) else begin
      $display("** Error @%0t: fetch_entry_o.cf = %0d, expected %0d", $time, e.cf, exp_cf);
      errs++;
    end
    // the predicted next pc must be the pc of the following entry
    if (i < N - 1) begin
      assert (e.predict_target == exp_pc[r][i + 1]) else begin
        $display("** Error @%0t: fetch_entry_o.predict_target = %h, expected %h",
                 $time, e.predict_target, exp_pc[r][i + 1]);
        errs++;
      end
    end
  endtask

  task automatic run_row(input int r);
    row_t         row;
    fetch_entry_t e;
    int           got;
    int           cycles;
    int           errs;
    row  = rows[r];
    errs = 0;
    // decode is held off while the backend changes the path
    if (row.kind != K_BOOT) begin
      if (row.train) begin
        @(posedge clk_i);
        resolve <= '{valid: 1'b1, is_branch: 1'b1, pc: row.train_pc, taken: 1'b0,
                     mispredict: 1'b0, target: '0};
      end
      @(posedge clk_i);
      if (row.kind == K_REDIRECT) begin
        resolve  <= '0;
        redirect <= '{valid: 1'b1, target: row.target};
      end else begin
        resolve <= '{valid: 1'b1, is_branch: 1'b0, pc: '0, taken: 1'b1,
                     mispredict: 1'b1, target: row.target};
      end
      @(posedge clk_i);
      redirect <= '0;
      resolve  <= '0;
    end
    fetch_ready <= pick_ready(row.rand_ready);
    got    = 0;
    cycles = 0;
    while ((got < N) && (cycles < TIMEOUT)) begin
      @(posedge clk_i);
      cycles++;
      if (fetch_valid && fetch_ready) begin
        e = fetch_entry;
        check_entry(r, got, e, errs);
        got++;
      end
      fetch_ready <= (got < N) ? pick_ready(row.rand_ready) : 1'b0;
    end
    if (got < N) begin
      $display("test %0d: timed out after %0d cycles with only %0d of %0d entries",
               r, cycles, got, N);
      errs++;
    end
    $display("test %0d (%s): %s, %0d errors", r, names[r], (errs == 0) ? "ok" : "failed", errs);
    errors += errs;
    if (errs != 0) begin
      failed_tests++;
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(71));
    errors       = 0;
    failed_tests = 0;
    rst_ni       = 1'b0;
    load_table();
    boot_addr    = rows[0].target;
    redirect     = '0;
    resolve      = '0;
    fetch_ready  = 1'b0;
    repeat (10) @(posedge clk_i);
    // nothing requested or offered while reset is held
    assert (!fetch_req.valid && !fetch_valid) else begin
      $display("** Error @%0t: fetch_req_o.valid = %b, fetch_valid_o = %b, expected 0 and 0",
               $time, fetch_req.valid, fetch_valid);
      errors++;
    end
    rst_ni <= 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("summary: %0d of %0d tests passed, %0d errors",
             NUM_ROWS - failed_tests, NUM_ROWS, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- bench/tb_imem.sv
// in-order memory model; grant and response each wait 0 to 3 cycles, unlisted addresses read as nop
module tb_imem
  import frontend_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  fetch_req_t req_i,
  output logic       gnt_o,
  output fetch_rsp_t rsp_o
);

  localparam logic [ILEN-1:0] NOP = 32'h0000_0013;

  // granted requests waiting for their response, oldest first
  logic [VLEN-1:0] pend_addr [$];
  logic [ID_W-1:0] pend_id [$];
  logic            gnt_q    = 1'b0;
  fetch_rsp_t      rsp_q    = '0;
  int unsigned     gnt_wait = 0;
  int unsigned     rsp_wait = 0;

  assign gnt_o = gnt_q;
  assign rsp_o = rsp_q;

  // program image, one word per address
  function automatic logic [ILEN-1:0] program_word(input logic [VLEN-1:0] addr);
    case (addr)
      32'h0000_100C: program_word = 32'h0200_006F;  // jal x0, +32
      32'h0000_2008: program_word = 32'hFE00_0CE3;  // beq x0, x0, -8
      32'h0000_3004: program_word = 32'h0000_0863;  // beq x0, x0, +16
      32'h0000_4010: program_word = 32'hFF1F_F06F;  // jal x0, -16
      default:       program_word = NOP;
    endcase
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q    <= 1'b0;
      rsp_q    <= '0;
      gnt_wait <= 0;
      rsp_wait <= 0;
      pend_addr.delete();
      pend_id.delete();
    end else begin
      // --------------------------------------------------
      // grant side
      // --------------------------------------------------
      if (req_i.valid && gnt_q) begin
        // transfer in the cycle just ended
        pend_addr.push_back(req_i.addr);
        pend_id.push_back(req_i.id);
        gnt_q    <= 1'b0;
        gnt_wait <= $urandom_range(3, 0);
      end else if (req_i.valid) begin
        if (gnt_wait == 0) begin
          gnt_q <= 1'b1;
        end else begin
          gnt_wait <= gnt_wait - 1;
        end
      end
      // --------------------------------------------------
      // response side, strictly in grant order
      // --------------------------------------------------
      rsp_q.valid <= 1'b0;
      if (pend_addr.size() != 0) begin
        if (rsp_wait == 0) begin
          rsp_q.valid <= 1'b1;
          rsp_q.id    <= pend_id.pop_front();
          rsp_q.data  <= program_word(pend_addr.pop_front());
          rsp_wait    <= $urandom_range(3, 0);
        end else begin
          rsp_wait <= rsp_wait - 1;
        end
      end
    end
  end

endmodule

//--- verilog/fetch_frontend.sv
// memory must answer every granted request exactly once; decode may stall but not drop entries
module fetch_frontend
  import frontend_pkg::*;
#(
  parameter int unsigned NR_OUTSTANDING = DEF_NR_OUTSTANDING,
  parameter int unsigned QUEUE_DEPTH    = DEF_QUEUE_DEPTH,
  parameter int unsigned BHT_ENTRIES    = DEF_BHT_ENTRIES
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic [VLEN-1:0] boot_addr_i,
  input  redirect_t       redirect_i,
  input  resolve_t        resolve_i,
  output fetch_req_t      fetch_req_o,
  input  logic            fetch_gnt_i,
  input  fetch_rsp_t      fetch_rsp_i,
  output fetch_entry_t    fetch_entry_o,
  output logic            fetch_valid_o,
  input  logic            fetch_ready_i
);

  logic [VLEN-1:0] fetch_addr;
  logic [ID_W-1:0] alloc_id;
  logic            buf_full;
  logic [3:0]      live_count;
  logic [3:0]      queue_free;
  logic            rsp_live;
  logic [VLEN-1:0] rsp_pc;
  logic            is_branch, is_jal;
  logic [VLEN-1:0] imm;
  logic            bht_valid, bht_taken;
  bht_update_t     bht_update;
  fetch_entry_t    entry;
  logic            flush, kill, push, predict_taken, predict_valid;
  logic            can_issue, grant, stale_grant;
  // request waiting for grant, its fields are frozen
  logic            req_wait_q;
  fetch_req_t      req_hold_q;
  // set when a kill hit the waiting request
  logic            stale_q;
  // low in reset and in the boot load cycle, no request leaves before that
  logic            issue_en_q;

  // --------------------------------------------------
  // kill and predict decision
  // --------------------------------------------------
  assign flush = redirect_i.valid | (resolve_i.valid & resolve_i.mispredict);
  // a live response in a flush cycle is wrong path already
  assign push  = rsp_live & ~flush;
  always_comb begin
    predict_taken = is_jal;
    if (is_branch) begin
      // static fallback, backward taken
      predict_taken = bht_valid ? bht_taken : imm[VLEN-1];
    end
  end
  assign predict_valid = push & predict_taken;
  assign kill          = flush | predict_valid;

  assign entry.pc             = rsp_pc;
  assign entry.instr          = fetch_rsp_i.data;
  assign entry.cf             = is_jal ? CF_JUMP : (is_branch ? CF_BRANCH : CF_NONE);
  assign entry.predict_taken  = predict_taken;
  assign entry.predict_target = predict_taken ? rsp_pc + imm : rsp_pc + VLEN'(4);

  assign bht_update.valid = resolve_i.valid & resolve_i.is_branch;
  assign bht_update.pc    = resolve_i.pc;
  assign bht_update.taken = resolve_i.taken;

  // --------------------------------------------------
  // request issue
  // --------------------------------------------------
  // every live fetch plus this one needs a queue slot
  assign can_issue = issue_en_q & (queue_free > live_count) & ~buf_full;
  always_comb begin
    fetch_req_o.valid = can_issue;
    fetch_req_o.addr  = fetch_addr;
    fetch_req_o.id    = alloc_id;
    if (req_wait_q) begin
      fetch_req_o = req_hold_q;
    end
  end
  assign grant       = fetch_req_o.valid & fetch_gnt_i;
  // pc already moved on, so no advance and the slot goes in killed
  assign stale_grant = grant & req_wait_q & stale_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_wait_q <= 1'b0;
      stale_q    <= 1'b0;
      issue_en_q <= 1'b0;
    end else begin
      req_wait_q <= fetch_req_o.valid & ~fetch_gnt_i;
      stale_q    <= fetch_req_o.valid & ~fetch_gnt_i & ((req_wait_q & stale_q) | kill);
      issue_en_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_req_o.valid && !fetch_gnt_i) begin
      req_hold_q <= fetch_req_o;
    end
  end

  // --------------------------------------------------
  // stages
  // --------------------------------------------------
  pc_gen i_pc_gen (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .boot_addr_i     (boot_addr_i),
    .redirect_i      (redirect_i),
    .resolve_i       (resolve_i),
    .predict_valid_i (predict_valid),
    .predict_target_i(entry.predict_target),
    .advance_i       (grant & ~stale_grant),
    .fetch_addr_o    (fetch_addr)
  );

  fetch_buffer #(
    .NR_OUTSTANDING(NR_OUTSTANDING)
  ) i_fetch_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .kill_i      (kill | stale_grant),
    .alloc_i     (grant),
    .alloc_addr_i(fetch_req_o.addr),
    .rsp_i       (fetch_rsp_i),
    .alloc_id_o  (alloc_id),
    .full_o      (buf_full),
    .live_count_o(live_count),
    .rsp_live_o  (rsp_live),
    .rsp_pc_o    (rsp_pc)
  );

  instr_scan i_instr_scan (
    .instr_i    (fetch_rsp_i.data),
    .is_branch_o(is_branch),
    .is_jal_o   (is_jal),
    .imm_o      (imm)
  );

  bht #(
    .BHT_ENTRIES(BHT_ENTRIES)
  ) i_bht (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .read_pc_i(rsp_pc),
    .update_i (bht_update),
    .valid_o  (bht_valid),
    .taken_o  (bht_taken)
  );

  instr_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) i_instr_queue (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .flush_i(flush),
    .push_i (push),
    .entry_i(entry),
    .ready_i(fetch_ready_i),
    .entry_o(fetch_entry_o),
    .valid_o(fetch_valid_o),
    .free_o (queue_free)
  );

endmodule

//--- verilog/instr_queue.sv
// QUEUE_DEPTH from 2 to 15; push while full is not allowed, the caller must check free_o
module instr_queue
  import frontend_pkg::*;
#(
  parameter int unsigned QUEUE_DEPTH = DEF_QUEUE_DEPTH
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flush_i,
  input  logic         push_i,
  input  fetch_entry_t entry_i,
  input  logic         ready_i,
  output fetch_entry_t entry_o,
  output logic         valid_o,
  output logic [3:0]   free_o
);

  localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);
  localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

  fetch_entry_t     mem_q [QUEUE_DEPTH];
  logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             pop;

  // wrap by compare so a depth that is no power of two still works
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign valid_o = (count_q != '0);
  assign entry_o = mem_q[rd_ptr_q];
  assign pop     = valid_o & ready_i;
  assign free_o  = 4'(QUEUE_DEPTH) - 4'(count_q);

  // --------------------------------------------------
  // pointers and fill level
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // whole queue is wrong path after a backend redirect
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  // the issue credit upstream must keep room for every live response
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> free_o != '0)
    else $error("instr_queue: push into full queue");

endmodule

//--- verilog/bht.sv
// BHT_ENTRIES must be a power of two; aliasing pcs share a counter
module bht
  import frontend_pkg::*;
#(
  parameter int unsigned BHT_ENTRIES = DEF_BHT_ENTRIES
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic [VLEN-1:0] read_pc_i,
  input  bht_update_t     update_i,
  output logic            valid_o,
  output logic            taken_o
);

  localparam int unsigned IDX_W = $clog2(BHT_ENTRIES);

  logic [BHT_ENTRIES-1:0] valid_q;
  logic [1:0]             cntr_q [BHT_ENTRIES];
  logic [IDX_W-1:0]       rd_idx;
  logic [IDX_W-1:0]       up_idx;
  logic [1:0]             up_cntr;

  // word aligned pcs, bits 1:0 carry no information
  assign rd_idx = read_pc_i[IDX_W+1:2];
  assign up_idx = update_i.pc[IDX_W+1:2];

  // combinational read, msb of the counter is the direction
  assign valid_o = valid_q[rd_idx];
  assign taken_o = cntr_q[rd_idx][1];

  // --------------------------------------------------
  // counter update
  // --------------------------------------------------
  always_comb begin
    up_cntr = cntr_q[up_idx];
    if (!valid_q[up_idx]) begin
      // first outcome seen, start in the weak state of that direction
      up_cntr = update_i.taken ? 2'b10 : 2'b01;
    end else if (update_i.taken && (up_cntr != 2'b11)) begin
      up_cntr = up_cntr + 2'b01;
    end else if (!update_i.taken && (up_cntr != 2'b00)) begin
      up_cntr = up_cntr - 2'b01;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (update_i.valid) begin
      valid_q[up_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_i.valid) begin
      cntr_q[up_idx] <= up_cntr;
    end
  end

endmodule

//--- verilog/instr_scan.sv
// 32-bit encodings only; jalr and compressed instructions are not recognised here
module instr_scan
  import frontend_pkg::*;
(
  input  logic [ILEN-1:0] instr_i,
  output logic            is_branch_o,
  output logic            is_jal_o,
  output logic [VLEN-1:0] imm_o
);

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic [VLEN-1:0] b_imm;
  logic [VLEN-1:0] j_imm;

  assign is_branch_o = (instr_i[6:0] == OPC_BRANCH);
  assign is_jal_o    = (instr_i[6:0] == OPC_JAL);

  // b-type, 13 bit offset scattered over both ends of the word
  assign b_imm = {{(VLEN - 13){instr_i[31]}},
                  instr_i[31],
                  instr_i[7],
                  instr_i[30:25],
                  instr_i[11:8],
                  1'b0};

  // j-type, 21 bit offset
  assign j_imm = {{(VLEN - 21){instr_i[31]}},
                  instr_i[31],
                  instr_i[19:12],
                  instr_i[20],
                  instr_i[30:21],
                  1'b0};

  always_comb begin
    imm_o = '0;
    if (is_jal_o) begin
      imm_o = j_imm;
    end else if (is_branch_o) begin
      imm_o = b_imm;
    end
  end

endmodule

//--- verilog/fetch_buffer.sv
// NR_OUTSTANDING from 2 to 8; responses must carry the id of a slot that is still allocated
module fetch_buffer
  import frontend_pkg::*;
#(
  parameter int unsigned NR_OUTSTANDING = DEF_NR_OUTSTANDING
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            kill_i,
  input  logic            alloc_i,
  input  logic [VLEN-1:0] alloc_addr_i,
  input  fetch_rsp_t      rsp_i,
  output logic [ID_W-1:0] alloc_id_o,
  output logic            full_o,
  output logic [3:0]      live_count_o,
  output logic            rsp_live_o,
  output logic [VLEN-1:0] rsp_pc_o
);

  localparam int unsigned IDX_W = $clog2(NR_OUTSTANDING);

  logic [NR_OUTSTANDING-1:0] valid_d, valid_q;
  logic [NR_OUTSTANDING-1:0] killed_d, killed_q;
  logic [VLEN-1:0]           pc_q [NR_OUTSTANDING];
  // slot handed out on the next alloc, held steady while a request waits for grant
  logic [IDX_W-1:0]          next_q;
  logic [IDX_W-1:0]          free_idx;
  logic [IDX_W-1:0]          rsp_idx;

  assign rsp_idx    = rsp_i.id[IDX_W-1:0];
  assign alloc_id_o = ID_W'(next_q);
  assign full_o     = &valid_q;
  assign rsp_live_o = rsp_i.valid & valid_q[rsp_idx] & ~killed_q[rsp_idx];
  assign rsp_pc_o   = pc_q[rsp_idx];

  // --------------------------------------------------
  // slot bookkeeping
  // --------------------------------------------------
  always_comb begin
    valid_d  = valid_q;
    killed_d = killed_q;
    // flush marks everything in flight, responses come back but are dropped
    if (kill_i) begin
      killed_d = killed_q | valid_q;
    end
    if (rsp_i.valid) begin
      valid_d[rsp_idx] = 1'b0;
    end
    // a grant in a kill cycle carries an address from before the kill
    if (alloc_i) begin
      valid_d[next_q]  = 1'b1;
      killed_d[next_q] = kill_i;
    end
  end

  // lowest free slot after this cycle's updates
  always_comb begin
    free_idx = '0;
    for (int i = NR_OUTSTANDING - 1; i >= 0; i--) begin
      if (!valid_d[i]) begin
        free_idx = IDX_W'(i);
      end
    end
  end

  // live entries, used for the queue credit check
  always_comb begin
    live_count_o = '0;
    for (int i = 0; i < NR_OUTSTANDING; i++) begin
      live_count_o = live_count_o + {3'b000, valid_q[i] & ~killed_q[i]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      killed_q <= '0;
      next_q   <= '0;
    end else begin
      valid_q  <= valid_d;
      killed_q <= killed_d;
      // only re-pick when the held slot got used or is still busy
      if (alloc_i || valid_q[next_q]) begin
        next_q <= free_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      pc_q[next_q] <= alloc_addr_i;
    end
  end

  a_rsp_id_live: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_i.valid |-> (rsp_i.id < NR_OUTSTANDING) && valid_q[rsp_idx])
    else $error("fetch_buffer: response id %0d names no outstanding slot", rsp_i.id);

  a_alloc_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alloc_i |-> !valid_q[next_q])
    else $error("fetch_buffer: alloc into busy slot %0d", next_q);

endmodule

//--- verilog/pc_gen.sv
// boot_addr_i must be stable from reset release until the first fetch request is issued
module pc_gen
  import frontend_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic [VLEN-1:0] boot_addr_i,
  input  redirect_t       redirect_i,
  input  resolve_t        resolve_i,
  input  logic            predict_valid_i,
  input  logic [VLEN-1:0] predict_target_i,
  input  logic            advance_i,
  output logic [VLEN-1:0] fetch_addr_o
);

  logic [VLEN-1:0] pc_d, pc_q;
  // set for one cycle after reset, selects the boot address
  logic            boot_load_q;
  logic            mispredict;

  assign mispredict   = resolve_i.valid & resolve_i.mispredict;
  assign fetch_addr_o = boot_load_q ? boot_addr_i : pc_q;

  // --------------------------------------------------
  // next pc, lowest priority first
  // --------------------------------------------------
  always_comb begin
    // hold the current fetch address by default
    pc_d = fetch_addr_o;
    // sequential step once the request went out
    if (advance_i) begin
      pc_d = fetch_addr_o + VLEN'(4);
    end
    // taken prediction from the response stage
    if (predict_valid_i) begin
      pc_d = predict_target_i;
    end
    // resolved mispredict from execute
    if (mispredict) begin
      pc_d = resolve_i.target;
    end
    // trap, eret or any other flush wins over everything
    if (redirect_i.valid) begin
      pc_d = redirect_i.target;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_load_q <= 1'b1;
      pc_q        <= '0;
    end else begin
      boot_load_q <= 1'b0;
      pc_q        <= pc_d;
    end
  end

  // the backend and the response stage must never feed X into the pc mux
  a_redirect_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({redirect_i.valid, mispredict, predict_valid_i}))
    else $error("pc_gen: unknown redirect source");

endmodule

//--- verilog/frontend_pkg.sv
// shared by rtl and testbench; one 32-bit instruction per fetch, request ids are 3 bits wide
package frontend_pkg;

  // --------------------------------------------------
  // widths and parameter defaults
  // --------------------------------------------------
  localparam int unsigned VLEN = 32;
  localparam int unsigned ILEN = 32;
  // request id width, enough for up to 8 outstanding fetches
  localparam int unsigned ID_W = 3;

  // defaults only, the top level passes the real values down
  localparam int unsigned DEF_NR_OUTSTANDING = 4;
  localparam int unsigned DEF_QUEUE_DEPTH    = 8;
  localparam int unsigned DEF_BHT_ENTRIES    = 64;

  // predicted control flow class of a fetched instruction
  typedef enum logic [1:0] {
    CF_NONE   = 2'd0,
    CF_BRANCH = 2'd1,
    CF_JUMP   = 2'd2
  } cf_e;

  // --------------------------------------------------
  // memory side
  // --------------------------------------------------
  typedef struct packed {
    logic            valid;
    logic [VLEN-1:0] addr;
    logic [ID_W-1:0] id;
  } fetch_req_t;

  typedef struct packed {
    logic            valid;
    logic [ID_W-1:0] id;
    logic [ILEN-1:0] data;
  } fetch_rsp_t;

  // --------------------------------------------------
  // backend side
  // --------------------------------------------------
  typedef struct packed {
    logic            valid;
    logic            is_branch;
    logic [VLEN-1:0] pc;
    logic            taken;
    logic            mispredict;
    logic [VLEN-1:0] target;   // correct next pc
  } resolve_t;

  typedef struct packed {
    logic            valid;
    logic [VLEN-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic [VLEN-1:0] pc;
    logic [ILEN-1:0] instr;
    cf_e             cf;
    logic            predict_taken;
    logic [VLEN-1:0] predict_target;
  } fetch_entry_t;

  typedef struct packed {
    logic            valid;
    logic [VLEN-1:0] pc;
    logic            taken;
  } bht_update_t;

endpackage
